// File: design/msgq_cfg.svh
// Message queue configuration: word, address and ring widths.
`ifndef MSGQ_CFG_SVH
`define MSGQ_CFG_SVH

// ==================================================
// Data path
// ==================================================

// Message and SRAM word width.
`define MSGQ_DATA_BITS 32

// SRAM word address width, 256 words.
`define MSGQ_ADDR_BITS 8

// ==================================================
// Rings and host window
// ==================================================

// Index width of each ring, 128 entries per ring.
`define MSGQ_RING_BITS 7

// Host word address. Top bit picks the register window.
`define MSGQ_HOST_ADDR_BITS 10

`endif

// File: design/msgq_pkg.sv
// Message queue package: shared words, pointers, request structs and enums.
`include "msgq_cfg.svh"

package msgq_pkg;

	typedef logic [`MSGQ_DATA_BITS-1:0] word_t;

	// Ring index plus one wrap bit.
	typedef logic [`MSGQ_RING_BITS:0] ptr_t;

	typedef struct packed {
		logic [`MSGQ_HOST_ADDR_BITS-1:0] addr;
		logic                            write;
		word_t                           wdata;
		logic [`MSGQ_DATA_BITS/8-1:0]    be;
	} host_req_t;

	typedef struct packed {
		word_t rdata;
	} host_rsp_t;

	typedef struct packed {
		logic [`MSGQ_ADDR_BITS-1:0]   addr;
		logic                         write;
		word_t                        wdata;
		logic [`MSGQ_DATA_BITS/8-1:0] be;
	} sram_req_t;

	// Register offsets in the host register window.
	typedef enum logic [2:0] {
		REG_CTRL   = 3'd0,
		REG_H2D_WR = 3'd1,
		REG_H2D_RD = 3'd2,
		REG_D2H_WR = 3'd3,
		REG_D2H_RD = 3'd4,
		REG_STATUS = 3'd5
	} reg_addr_e;

	typedef enum logic [1:0] {
		IDLE,
		SEND,
		FETCH
	} eng_op_e;

	typedef struct packed {
		ptr_t h2d_wr;
		ptr_t h2d_rd;
		ptr_t d2h_wr;
		ptr_t d2h_rd;
	} qptrs_t;

	function automatic logic ring_empty(ptr_t wr, ptr_t rd);
		return wr == rd;
	endfunction

	// Same index, opposite wrap bit.
	function automatic logic ring_full(ptr_t wr, ptr_t rd);
		return (wr[`MSGQ_RING_BITS] != rd[`MSGQ_RING_BITS]) &&
			(wr[`MSGQ_RING_BITS-1:0] == rd[`MSGQ_RING_BITS-1:0]);
	endfunction

endpackage

// File: design/shared_sram.sv
// Shared SRAM: byte-enabled single-port array, engine-first arbiter, registered read.
`timescale 1ns/10ps
`include "msgq_cfg.svh"

module shared_sram (
	input  logic                clk,
	input  logic                reset,
	input  msgq_pkg::sram_req_t eng_req,
	input  logic                eng_valid,
	output logic                eng_gnt,
	input  msgq_pkg::sram_req_t host_req,
	input  logic                host_valid,
	output logic                host_gnt,
	output msgq_pkg::word_t     rdata
);

	localparam int DEPTH = 1 << `MSGQ_ADDR_BITS;
	localparam int LANES = `MSGQ_DATA_BITS / 8;

	msgq_pkg::word_t     mem [DEPTH];
	msgq_pkg::sram_req_t req;
	logic                req_valid;

	// ==================================================
	// Arbiter
	// ==================================================

	// Engine always wins.
	assign eng_gnt   = eng_valid;
	assign host_gnt  = host_valid && !eng_valid;
	assign req       = eng_valid ? eng_req : host_req;
	assign req_valid = eng_valid || host_valid;

	// ==================================================
	// Array
	// ==================================================

	always_ff @(posedge clk) begin
		if (req_valid && req.write) begin
			for (int i = 0; i < LANES; i++) begin
				if (req.be[i]) begin
					mem[req.addr][i*8 +: 8] <= req.wdata[i*8 +: 8];
				end
			end
		end
	end

	// Read data appears the cycle after the grant.
	always_ff @(posedge clk) begin
		if (req_valid && !req.write) begin
			rdata <= mem[req.addr];
		end
	end

	// Only one client may own the port in a cycle.
	gnt_onehot: assert property (@(posedge clk) disable iff (reset)
		!(eng_gnt && host_gnt))
		else $error("Both SRAM clients granted in one cycle.");

endmodule

// File: design/host_bus_bridge.sv
// Host bridge: splits host requests between SRAM and registers, one response each.
`timescale 1ns/10ps
`include "msgq_cfg.svh"

module host_bus_bridge (
	input  logic                  clk,
	input  logic                  reset,
	input  msgq_pkg::host_req_t   host_req,
	input  logic                  req_valid,
	output logic                  req_ready,
	output msgq_pkg::host_rsp_t   host_rsp,
	output logic                  rsp_valid,
	output msgq_pkg::sram_req_t   mem_req,
	output logic                  mem_valid,
	input  logic                  mem_gnt,
	input  msgq_pkg::word_t       mem_rdata,
	output logic                  reg_valid,
	output logic                  reg_write,
	output msgq_pkg::reg_addr_e   reg_addr,
	output msgq_pkg::word_t       reg_wdata,
	input  msgq_pkg::word_t       reg_rdata
);

	localparam int WIN_BIT  = `MSGQ_HOST_ADDR_BITS - 1;
	localparam int REG_BITS = $bits(msgq_pkg::reg_addr_e);

	logic is_reg;
	logic take;
	logic rsp_from_reg;

	assign is_reg = host_req.addr[WIN_BIT];

	// SRAM side.
	assign mem_valid     = req_valid && !is_reg;
	assign mem_req.addr  = host_req.addr[`MSGQ_ADDR_BITS-1:0];
	assign mem_req.write = host_req.write;
	assign mem_req.wdata = host_req.wdata;
	assign mem_req.be    = host_req.be;

	// Register side. A partial write counts as a read.
	assign reg_valid = req_valid && is_reg;
	assign reg_write = host_req.write && (&host_req.be);
	assign reg_addr  = msgq_pkg::reg_addr_e'(host_req.addr[REG_BITS-1:0]);
	assign reg_wdata = host_req.wdata;

	// Memory requests stall while the engine holds the SRAM.
	assign req_ready = is_reg || mem_gnt;
	assign take      = req_valid && req_ready;

	always_ff @(posedge clk) begin
		if (reset) begin
			rsp_valid <= 1'b0;
		end else begin
			rsp_valid <= take;
		end
	end

	// Remember the target for the response mux.
	always_ff @(posedge clk) begin
		if (take) begin
			rsp_from_reg <= is_reg;
		end
	end

	assign host_rsp.rdata = rsp_from_reg ? reg_rdata : mem_rdata;

endmodule

// File: design/msgq_regs.sv
// Queue registers: control, four ring pointers, status readback and interrupt.
`timescale 1ns/10ps
`include "msgq_cfg.svh"

module msgq_regs (
	input  logic                clk,
	input  logic                reset,
	input  logic                reg_valid,
	input  logic                reg_write,
	input  msgq_pkg::reg_addr_e reg_addr,
	input  msgq_pkg::word_t     reg_wdata,
	output msgq_pkg::word_t     reg_rdata,
	output msgq_pkg::qptrs_t    ptrs,
	input  logic                d2h_push,
	input  logic                h2d_pop,
	output logic                irq
);

	logic            irq_en;
	msgq_pkg::ptr_t  h2d_wr;
	msgq_pkg::ptr_t  h2d_rd;
	msgq_pkg::ptr_t  d2h_wr;
	msgq_pkg::ptr_t  d2h_rd;
	logic            wr_en;
	logic            d2h_pending;
	logic            h2d_pending;
	msgq_pkg::word_t status;

	assign wr_en       = reg_valid && reg_write;
	assign d2h_pending = !msgq_pkg::ring_empty(d2h_wr, d2h_rd);
	assign h2d_pending = !msgq_pkg::ring_empty(h2d_wr, h2d_rd);
	assign status      = msgq_pkg::word_t'({h2d_pending, d2h_pending});

	// ==================================================
	// Control state
	// ==================================================

	// Host owns H2D_WR and D2H_RD, the engine owns the other two.
	always_ff @(posedge clk) begin
		if (reset) begin
			irq_en <= 1'b0;
			h2d_wr <= '0;
			h2d_rd <= '0;
			d2h_wr <= '0;
			d2h_rd <= '0;
			irq    <= 1'b0;
		end else begin
			if (wr_en && reg_addr == msgq_pkg::REG_CTRL) begin
				irq_en <= reg_wdata[0];
			end
			if (wr_en && reg_addr == msgq_pkg::REG_H2D_WR) begin
				h2d_wr <= reg_wdata[`MSGQ_RING_BITS:0];
			end
			if (wr_en && reg_addr == msgq_pkg::REG_D2H_RD) begin
				d2h_rd <= reg_wdata[`MSGQ_RING_BITS:0];
			end
			if (h2d_pop) begin
				h2d_rd <= h2d_rd + 1'b1;
			end
			if (d2h_push) begin
				d2h_wr <= d2h_wr + 1'b1;
			end
			irq <= irq_en && d2h_pending;
		end
	end

	// Read data returns one cycle after the access.
	always_ff @(posedge clk) begin
		if (reg_valid) begin
			case (reg_addr)
				msgq_pkg::REG_CTRL:   reg_rdata <= msgq_pkg::word_t'(irq_en);
				msgq_pkg::REG_H2D_WR: reg_rdata <= msgq_pkg::word_t'(h2d_wr);
				msgq_pkg::REG_H2D_RD: reg_rdata <= msgq_pkg::word_t'(h2d_rd);
				msgq_pkg::REG_D2H_WR: reg_rdata <= msgq_pkg::word_t'(d2h_wr);
				msgq_pkg::REG_D2H_RD: reg_rdata <= msgq_pkg::word_t'(d2h_rd);
				msgq_pkg::REG_STATUS: reg_rdata <= status;
				default:              reg_rdata <= '0;
			endcase
		end
	end

	assign ptrs.h2d_wr = h2d_wr;
	assign ptrs.h2d_rd = h2d_rd;
	assign ptrs.d2h_wr = d2h_wr;
	assign ptrs.d2h_rd = d2h_rd;

	// The engine must not push into a full device-to-host ring.
	d2h_no_overrun: assert property (@(posedge clk) disable iff (reset)
		msgq_pkg::ring_full(d2h_wr, d2h_rd) |=> d2h_wr == $past(d2h_wr))
		else $error("D2H write pointer advanced on a full ring.");

endmodule

// File: design/msgq_engine.sv
// Queue engine: writes device sends into the D2H ring, fetches H2D words to the receive stream.
`timescale 1ns/10ps
`include "msgq_cfg.svh"

module msgq_engine (
	input  logic                clk,
	input  logic                reset,
	input  msgq_pkg::qptrs_t    ptrs,
	input  logic                snd_valid,
	input  msgq_pkg::word_t     snd_data,
	output logic                snd_ready,
	output logic                rcv_valid,
	output msgq_pkg::word_t     rcv_data,
	input  logic                rcv_ready,
	output msgq_pkg::sram_req_t mem_req,
	output logic                mem_valid,
	input  logic                mem_gnt,
	input  msgq_pkg::word_t     mem_rdata,
	output logic                d2h_push,
	output logic                h2d_pop
);

	logic              d2h_full;
	logic              h2d_empty;
	logic              out_free;
	logic              can_send;
	logic              can_fetch;
	logic              issue_send;
	logic              issue_fetch;
	msgq_pkg::eng_op_e op;
	msgq_pkg::eng_op_e last_op;
	// Set in the cycle where fetched data sits on the SRAM output.
	logic              fresh;
	msgq_pkg::word_t   hold_data;

	assign d2h_full  = msgq_pkg::ring_full(ptrs.d2h_wr, ptrs.d2h_rd);
	assign h2d_empty = msgq_pkg::ring_empty(ptrs.h2d_wr, ptrs.h2d_rd);

	// Output slot is free if empty or being drained now.
	assign out_free  = !rcv_valid || rcv_ready;
	assign can_send  = snd_valid && !d2h_full;
	assign can_fetch = !h2d_empty && out_free;

	// ==================================================
	// Operation select
	// ==================================================

	// Round robin when both sides want the SRAM.
	always_comb begin
		op = msgq_pkg::IDLE;
		if (can_send && can_fetch) begin
			op = (last_op == msgq_pkg::SEND) ? msgq_pkg::FETCH : msgq_pkg::SEND;
		end else if (can_send) begin
			op = msgq_pkg::SEND;
		end else if (can_fetch) begin
			op = msgq_pkg::FETCH;
		end
	end

	// D2H ring in the upper half, H2D ring in the lower half.
	always_comb begin
		mem_req.write = (op == msgq_pkg::SEND);
		mem_req.wdata = snd_data;
		mem_req.be    = '1;
		if (op == msgq_pkg::SEND) begin
			mem_req.addr = {1'b1, ptrs.d2h_wr[`MSGQ_RING_BITS-1:0]};
		end else begin
			mem_req.addr = {1'b0, ptrs.h2d_rd[`MSGQ_RING_BITS-1:0]};
		end
	end

	assign mem_valid   = (op != msgq_pkg::IDLE);
	assign issue_send  = (op == msgq_pkg::SEND) && mem_gnt;
	assign issue_fetch = (op == msgq_pkg::FETCH) && mem_gnt;

	assign snd_ready = issue_send;
	assign d2h_push  = issue_send;
	assign h2d_pop   = issue_fetch;

	// ==================================================
	// Receive output
	// ==================================================

	always_ff @(posedge clk) begin
		if (reset) begin
			last_op   <= msgq_pkg::IDLE;
			rcv_valid <= 1'b0;
			fresh     <= 1'b0;
		end else begin
			if (issue_send || issue_fetch) begin
				last_op <= op;
			end
			if (issue_fetch) begin
				rcv_valid <= 1'b1;
			end else if (rcv_ready) begin
				rcv_valid <= 1'b0;
			end
			fresh <= issue_fetch;
		end
	end

	// Keep the word once the SRAM output may move on.
	always_ff @(posedge clk) begin
		if (fresh) begin
			hold_data <= mem_rdata;
		end
	end

	assign rcv_data = fresh ? mem_rdata : hold_data;

	// Held output must not change under backpressure.
	rcv_stable: assert property (@(posedge clk) disable iff (reset)
		rcv_valid && !rcv_ready |=> rcv_valid && $stable(rcv_data))
		else $error("Receive data changed while held.");

endmodule

// File: design/msgq_top.sv
// Message queue top: host bridge, registers, engine and shared SRAM.
`timescale 1ns/10ps

module msgq_top (
	input  logic                clk,
	input  logic                reset,
	input  msgq_pkg::host_req_t host_req,
	input  logic                req_valid,
	output logic                req_ready,
	output msgq_pkg::host_rsp_t host_rsp,
	output logic                rsp_valid,
	input  logic                snd_valid,
	input  msgq_pkg::word_t     snd_data,
	output logic                snd_ready,
	output logic                rcv_valid,
	output msgq_pkg::word_t     rcv_data,
	input  logic                rcv_ready,
	output logic                irq
);

	// SRAM clients.
	msgq_pkg::sram_req_t eng_mem_req;
	logic                eng_mem_valid;
	logic                eng_mem_gnt;
	msgq_pkg::sram_req_t host_mem_req;
	logic                host_mem_valid;
	logic                host_mem_gnt;
	msgq_pkg::word_t     sram_rdata;

	// Register access and pointer updates.
	logic                reg_valid;
	logic                reg_write;
	msgq_pkg::reg_addr_e reg_addr;
	msgq_pkg::word_t     reg_wdata;
	msgq_pkg::word_t     reg_rdata;
	msgq_pkg::qptrs_t    ptrs;
	logic                d2h_push;
	logic                h2d_pop;

	host_bus_bridge u_bridge (
		.clk       (clk),
		.reset     (reset),
		.host_req  (host_req),
		.req_valid (req_valid),
		.req_ready (req_ready),
		.host_rsp  (host_rsp),
		.rsp_valid (rsp_valid),
		.mem_req   (host_mem_req),
		.mem_valid (host_mem_valid),
		.mem_gnt   (host_mem_gnt),
		.mem_rdata (sram_rdata),
		.reg_valid (reg_valid),
		.reg_write (reg_write),
		.reg_addr  (reg_addr),
		.reg_wdata (reg_wdata),
		.reg_rdata (reg_rdata)
	);

	msgq_regs u_regs (
		.clk       (clk),
		.reset     (reset),
		.reg_valid (reg_valid),
		.reg_write (reg_write),
		.reg_addr  (reg_addr),
		.reg_wdata (reg_wdata),
		.reg_rdata (reg_rdata),
		.ptrs      (ptrs),
		.d2h_push  (d2h_push),
		.h2d_pop   (h2d_pop),
		.irq       (irq)
	);

	msgq_engine u_engine (
		.clk       (clk),
		.reset     (reset),
		.ptrs      (ptrs),
		.snd_valid (snd_valid),
		.snd_data  (snd_data),
		.snd_ready (snd_ready),
		.rcv_valid (rcv_valid),
		.rcv_data  (rcv_data),
		.rcv_ready (rcv_ready),
		.mem_req   (eng_mem_req),
		.mem_valid (eng_mem_valid),
		.mem_gnt   (eng_mem_gnt),
		.mem_rdata (sram_rdata),
		.d2h_push  (d2h_push),
		.h2d_pop   (h2d_pop)
	);

	shared_sram u_sram (
		.clk        (clk),
		.reset      (reset),
		.eng_req    (eng_mem_req),
		.eng_valid  (eng_mem_valid),
		.eng_gnt    (eng_mem_gnt),
		.host_req   (host_mem_req),
		.host_valid (host_mem_valid),
		.host_gnt   (host_mem_gnt),
		.rdata      (sram_rdata)
	);

endmodule

// File: sim/msgq_tb.sv
// Message queue testbench driving directed host and device traffic with checked responses.
`timescale 1ns/10ps
`include "msgq_cfg.svh"

module msgq_tb;

	typedef logic [`MSGQ_HOST_ADDR_BITS-1:0] haddr_t;

	// About four times the summed test lengths.
	localparam int     TIMEOUT_CYCLES = 4000;
	localparam int     DRIVE_DELAY    = 1;
	localparam haddr_t REG_BASE       = haddr_t'(1) << (`MSGQ_HOST_ADDR_BITS - 1);
	localparam haddr_t D2H_BASE       = haddr_t'(128);

	logic                clk;
	logic                reset;
	msgq_pkg::host_req_t host_req;
	logic                req_valid;
	logic                req_ready;
	msgq_pkg::host_rsp_t host_rsp;
	logic                rsp_valid;
	logic                snd_valid;
	msgq_pkg::word_t     snd_data;
	logic                snd_ready;
	logic                rcv_valid;
	msgq_pkg::word_t     rcv_data;
	logic                rcv_ready;
	logic                irq;
	msgq_pkg::word_t     rng_state = 32'd68487;
	int                  cycles = 0;
	logic                took_req;

	msgq_top dut0 (
		.clk       (clk),
		.reset     (reset),
		.host_req  (host_req),
		.req_valid (req_valid),
		.req_ready (req_ready),
		.host_rsp  (host_rsp),
		.rsp_valid (rsp_valid),
		.snd_valid (snd_valid),
		.snd_data  (snd_data),
		.snd_ready (snd_ready),
		.rcv_valid (rcv_valid),
		.rcv_data  (rcv_data),
		.rcv_ready (rcv_ready),
		.irq       (irq)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// ==================================================
	// Helpers and compare tasks
	// ==================================================

	function automatic msgq_pkg::word_t next_random();
		rng_state = rng_state ^ (rng_state << 13);
		rng_state = rng_state ^ (rng_state >> 17);
		rng_state = rng_state ^ (rng_state << 5);
		return rng_state;
	endfunction

	function automatic haddr_t reg_window_addr(msgq_pkg::reg_addr_e r);
		return REG_BASE | haddr_t'(r);
	endfunction

	task automatic stop_on_error(input string why);
		$display("%s", why);
		$display("TEST RESULT: FAIL");
		$fatal(1, "Stopped at the first error.");
	endtask

	task automatic check_word(input string name, input msgq_pkg::word_t got,
		input msgq_pkg::word_t exp);
		if (got !== exp) begin
			stop_on_error($sformatf("Fail %s: got 0x%h, expected 0x%h", name, got, exp));
		end
	endtask

	task automatic check_ptr(input string name, input msgq_pkg::ptr_t got,
		input msgq_pkg::ptr_t exp);
		if (got !== exp) begin
			stop_on_error($sformatf("Fail %s: got 0x%h, expected 0x%h", name, got, exp));
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			stop_on_error($sformatf("Fail %s: got 0x%h, expected 0x%h", name, got, exp));
		end
	endtask

	// Outputs are sampled mid-cycle and inputs change just after the edge.
	task automatic to_sample_point();
		@(negedge clk);
	endtask

	task automatic to_drive_point();
		@(posedge clk);
		#(DRIVE_DELAY);
	endtask

	task automatic apply_reset();
		reset     = 1'b1;
		req_valid = 1'b0;
		snd_valid = 1'b0;
		rcv_ready = 1'b0;
		repeat (3) @(posedge clk);
		#(DRIVE_DELAY);
		reset = 1'b0;
	endtask

	// ==================================================
	// Host and device tasks
	// ==================================================

	task automatic host_access(input haddr_t addr, input logic write,
		input msgq_pkg::word_t wdata, input logic [3:0] be, output msgq_pkg::word_t rdata);
		req_valid      = 1'b1;
		host_req.addr  = addr;
		host_req.write = write;
		host_req.wdata = wdata;
		host_req.be    = be;
		to_sample_point();
		while (!req_ready) begin
			to_sample_point();
		end
		to_drive_point();
		req_valid = 1'b0;
		// Response is due exactly one cycle after the transfer.
		to_sample_point();
		check_flag("rsp_valid", rsp_valid, 1'b1);
		rdata = host_rsp.rdata;
		to_drive_point();
	endtask

	task automatic host_write(input haddr_t addr, input msgq_pkg::word_t data,
		input logic [3:0] be);
		msgq_pkg::word_t unused;
		host_access(addr, 1'b1, data, be, unused);
	endtask

	task automatic host_read(input haddr_t addr, output msgq_pkg::word_t data);
		host_access(addr, 1'b0, '0, 4'hf, data);
	endtask

	task automatic expect_pointer(input string name, input msgq_pkg::reg_addr_e r,
		input msgq_pkg::ptr_t exp);
		msgq_pkg::word_t d;
		host_read(reg_window_addr(r), d);
		check_ptr(name, d[`MSGQ_RING_BITS:0], exp);
	endtask

	task automatic device_send(input msgq_pkg::word_t data);
		snd_valid = 1'b1;
		snd_data  = data;
		to_sample_point();
		while (!snd_ready) begin
			to_sample_point();
		end
		to_drive_point();
		snd_valid = 1'b0;
	endtask

	task automatic device_receive(input msgq_pkg::word_t exp);
		logic            done;
		msgq_pkg::word_t r;
		done = 1'b0;
		while (!done) begin
			r         = next_random();
			rcv_ready = r[0];
			to_sample_point();
			if (rcv_valid && rcv_ready) begin
				check_word("rcv_data", rcv_data, exp);
				done = 1'b1;
			end
			to_drive_point();
		end
		rcv_ready = 1'b0;
	endtask

	// ==================================================
	// Directed tests
	// ==================================================

	task automatic reset_values();
		msgq_pkg::word_t d;
		apply_reset();
		for (int r = 0; r < 6; r++) begin
			host_read(reg_window_addr(msgq_pkg::reg_addr_e'(r)), d);
			check_word("reg_rdata", d, '0);
		end
		to_sample_point();
		check_flag("irq", irq, 1'b0);
		check_flag("rcv_valid", rcv_valid, 1'b0);
		check_flag("snd_ready", snd_ready, 1'b0);
		to_drive_point();
	endtask

	task automatic memory_readback();
		msgq_pkg::word_t words [16];
		haddr_t          addrs [16];
		msgq_pkg::word_t d;
		apply_reset();
		// One address in each block of 16 words.
		for (int i = 0; i < 16; i++) begin
			addrs[i] = haddr_t'(i * 16) | haddr_t'(next_random() & 32'hf);
			words[i] = next_random();
			host_write(addrs[i], words[i], 4'hf);
		end
		for (int i = 0; i < 16; i++) begin
			host_read(addrs[i], d);
			check_word("host_rsp.rdata", d, words[i]);
		end
		// Two byte lanes only.
		host_write(haddr_t'(200), 32'hffff_ffff, 4'hf);
		host_write(haddr_t'(200), 32'h0000_0000, 4'b0101);
		host_read(haddr_t'(200), d);
		check_word("host_rsp.rdata", d, 32'hff00_ff00);
		host_write(reg_window_addr(msgq_pkg::REG_H2D_RD), 32'd5, 4'hf);
		expect_pointer("H2D_RD", msgq_pkg::REG_H2D_RD, '0);
	endtask

	task automatic send_to_host();
		msgq_pkg::word_t sent [20];
		msgq_pkg::word_t d;
		apply_reset();
		host_write(reg_window_addr(msgq_pkg::REG_CTRL), 32'd1, 4'hf);
		for (int i = 0; i < 20; i++) begin
			sent[i] = next_random();
			device_send(sent[i]);
		end
		expect_pointer("D2H_WR", msgq_pkg::REG_D2H_WR, 8'd20);
		for (int i = 0; i < 20; i++) begin
			host_read(D2H_BASE + haddr_t'(i), d);
			check_word("host_rsp.rdata", d, sent[i]);
		end
		to_sample_point();
		check_flag("irq", irq, 1'b1);
		to_drive_point();
		// Interrupt pending and H2D ring empty.
		host_read(reg_window_addr(msgq_pkg::REG_STATUS), d);
		check_word("STATUS", d, 32'h0000_0001);
		host_write(reg_window_addr(msgq_pkg::REG_D2H_RD), 32'd20, 4'hf);
		to_sample_point();
		check_flag("irq", irq, 1'b0);
		to_drive_point();
	endtask

	task automatic receive_from_host();
		msgq_pkg::word_t words [30];
		msgq_pkg::word_t d;
		apply_reset();
		for (int i = 0; i < 30; i++) begin
			words[i] = next_random();
			host_write(haddr_t'(i), words[i], 4'hf);
		end
		host_write(reg_window_addr(msgq_pkg::REG_H2D_WR), 32'd30, 4'hf);
		// H2D ring pending and D2H ring empty.
		host_read(reg_window_addr(msgq_pkg::REG_STATUS), d);
		check_word("STATUS", d, 32'h0000_0002);
		for (int i = 0; i < 30; i++) begin
			device_receive(words[i]);
		end
		expect_pointer("H2D_RD", msgq_pkg::REG_H2D_RD, 8'd30);
	endtask

	task automatic full_ring_wait();
		msgq_pkg::word_t sent [129];
		msgq_pkg::word_t d;
		apply_reset();
		for (int i = 0; i < 129; i++) begin
			sent[i] = next_random();
		end
		for (int i = 0; i < 128; i++) begin
			device_send(sent[i]);
		end
		expect_pointer("D2H_WR", msgq_pkg::REG_D2H_WR, 8'h80);
		// Ring holds data but CTRL leaves the interrupt disabled.
		to_sample_point();
		check_flag("irq", irq, 1'b0);
		to_drive_point();
		// The last word waits until the host frees one slot.
		fork
			device_send(sent[128]);
			begin
				repeat (3) begin
					to_sample_point();
					check_flag("snd_ready", snd_ready, 1'b0);
				end
				to_drive_point();
				host_write(reg_window_addr(msgq_pkg::REG_D2H_RD), 32'd1, 4'hf);
			end
		join
		host_read(D2H_BASE, d);
		check_word("host_rsp.rdata", d, sent[128]);
		for (int i = 1; i < 128; i++) begin
			host_read(D2H_BASE + haddr_t'(i), d);
			check_word("host_rsp.rdata", d, sent[i]);
		end
		expect_pointer("D2H_WR", msgq_pkg::REG_D2H_WR, 8'h81);
	endtask

	task automatic overlapped_traffic();
		msgq_pkg::word_t stored [16];
		msgq_pkg::word_t sent [16];
		int              gaps [16];
		msgq_pkg::word_t d;
		apply_reset();
		for (int i = 0; i < 16; i++) begin
			stored[i] = next_random();
			sent[i]   = next_random();
			gaps[i]   = int'(next_random() % 3);
			host_write(haddr_t'(64 + i), stored[i], 4'hf);
		end
		fork
			for (int i = 0; i < 16; i++) begin
				repeat (gaps[i]) to_drive_point();
				device_send(sent[i]);
			end
			for (int i = 0; i < 16; i++) begin
				host_read(haddr_t'(64 + i), d);
				check_word("host_rsp.rdata", d, stored[i]);
			end
		join
		for (int i = 0; i < 16; i++) begin
			host_read(D2H_BASE + haddr_t'(i), d);
			check_word("host_rsp.rdata", d, sent[i]);
		end
		expect_pointer("D2H_WR", msgq_pkg::REG_D2H_WR, 8'd16);
	endtask

	// ==================================================
	// Monitors and run control
	// ==================================================

	// One response for each transfer and only in the next cycle.
	always @(negedge clk) begin
		if (reset !== 1'b0) begin
			took_req = 1'b0;
		end else begin
			check_flag("rsp_valid", rsp_valid, took_req);
			took_req = req_valid && req_ready;
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= TIMEOUT_CYCLES) begin
			stop_on_error($sformatf("Timeout: tests still running after %0d cycles.", cycles));
		end
	end

	initial begin
		host_req = '0;
		snd_data = '0;
		reset_values();
		memory_readback();
		send_to_host();
		receive_from_host();
		full_ring_wait();
		overlapped_traffic();
		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

// File: src.f
+incdir+design
design/msgq_pkg.sv
design/shared_sram.sv
design/host_bus_bridge.sv
design/msgq_regs.sv
design/msgq_engine.sv
design/msgq_top.sv
sim/msgq_tb.sv

// File: Bender.yml
package:
  name: msgq

export_include_dirs:
  - design

sources:
  - design/msgq_pkg.sv
  - design/shared_sram.sv
  - design/host_bus_bridge.sv
  - design/msgq_regs.sv
  - design/msgq_engine.sv
  - design/msgq_top.sv
  - target: simulation
    files:
      - sim/msgq_tb.sv
